// ==== files.f ====
logic/soc_bus_pkg.sv
logic/soc_bus_if.sv
logic/bus_addr_decoder.sv
logic/scratch_ram.sv
logic/net_config_regs.sv
logic/led_page_view.sv
logic/soc_bus_top.sv
verification/tb_clock_gen.sv
verification/soc_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= soc_bus_tb
RTL_TOP   ?= soc_bus_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim lint build clean

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb;

	localparam int          RAM_WORDS       = 256;
	localparam int          DEBOUNCE_CYCLES = 4;
	localparam logic [31:0] DEF_BOARD_IP    = {8'd169, 8'd254, 8'd109, 8'd5};
	localparam logic [31:0] DEF_HOST_IP     = {8'd169, 8'd254, 8'd109, 8'd183};
	localparam logic [47:0] DEF_BOARD_MAC   = 48'h12_34_56_78_9A_BC;
	localparam logic [47:0] DEF_HOST_MAC    = 48'h84_47_09_4C_47_7C;
	localparam logic [31:0] FPGA_VERSION    = 32'h0001_0000;
	localparam logic [31:0] LED_BASE        = 32'h3000_0000;
	localparam logic [31:0] CFG_BASE        = 32'h7000_0000;
	localparam int          TIMEOUT_CYCLES  = 64;
	localparam int          RAND_SEED       = 89;
	localparam int          RAM_WRITES      = 60;

	typedef struct packed {
		logic [31:0] addr;
		logic [1:0]  resp;
		logic [31:0] data;
	} expect_t;

	logic        clk;
	logic        arst_n;
	logic        req_valid;
	logic        req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic [3:0]  req_strb;
	logic        rsp_ready;
	logic        btn_up;
	logic        btn_down;
	logic        req_ready;
	logic        rsp_valid;
	logic [31:0] rsp_rdata;
	logic [1:0]  rsp_resp;
	logic [7:0]  led8;
	logic [3:0]  led4;
	logic [31:0] board_ip;
	logic [47:0] board_mac;

	expect_t     exp_q [$]; // one entry per request in flight or queued
	logic [31:0] ram_model [RAM_WORDS];
	logic [31:0] cfg_board_ip;
	logic [31:0] cfg_host_ip;
	logic [47:0] cfg_board_mac;
	logic [47:0] cfg_host_mac;
	logic [7:0]  page_model [8];
	logic [2:0]  page_idx_model;
	logic [31:0] addr_list [RAM_WRITES];

	tb_clock_gen u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	soc_bus_top #(
		.RAM_WORDS       (RAM_WORDS),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.DEF_BOARD_IP    (DEF_BOARD_IP),
		.DEF_HOST_IP     (DEF_HOST_IP),
		.DEF_BOARD_MAC   (DEF_BOARD_MAC),
		.DEF_HOST_MAC    (DEF_HOST_MAC),
		.FPGA_VERSION    (FPGA_VERSION)
	) i_soc_bus_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_strb  (req_strb),
		.rsp_ready (rsp_ready),
		.btn_up    (btn_up),
		.btn_down  (btn_down),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_resp  (rsp_resp),
		.led8      (led8),
		.led4      (led4),
		.board_ip  (board_ip),
		.board_mac (board_mac)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("** Error at time %0t: %s: got 0x%0h, expected 0x%0h",
				$time, what, got, exp));
		end
	endtask

	function automatic logic ram_hit(input logic [31:0] addr);
		return addr <= 32'h0FFF_FFFF;
	endfunction

	function automatic logic led_hit(input logic [31:0] addr);
		return addr >= 32'h3000_0000 && addr <= 32'h3FFF_FFFF;
	endfunction

	function automatic logic cfg_hit(input logic [31:0] addr);
		return addr >= 32'h7000_0000 && addr <= 32'h7FFF_FFFF;
	endfunction

	// reference model for reads
	function automatic expect_t expected_read(input logic [31:0] addr);
		expect_t e;
		e.addr = addr;
		e.resp = soc_bus_pkg::RESP_OKAY;
		e.data = 32'h0;
		if (ram_hit(addr)) begin
			e.data = ram_model[int'((addr >> 2) % 32'(RAM_WORDS))]; // aliases in the window
		end else if (led_hit(addr)) begin
			e.data = {24'h0, page_model[addr[4:2]]};
		end else if (cfg_hit(addr)) begin
			case (addr[4:2])
				3'd0:    e.data = cfg_board_ip;
				3'd1:    e.data = cfg_host_ip;
				3'd2:    e.data = {16'h0, cfg_board_mac[47:32]};
				3'd3:    e.data = cfg_board_mac[31:0];
				3'd4:    e.data = {16'h0, cfg_host_mac[47:32]};
				3'd5:    e.data = cfg_host_mac[31:0];
				3'd6:    e.data = FPGA_VERSION;
				default: e.data = 32'h0;
			endcase
		end else begin
			e.resp = soc_bus_pkg::RESP_DECERR;
		end
		return e;
	endfunction

	function automatic logic [1:0] expected_write_resp(input logic [31:0] addr);
		if (!ram_hit(addr) && !led_hit(addr) && !cfg_hit(addr)) begin
			return soc_bus_pkg::RESP_DECERR;
		end else if (cfg_hit(addr) && addr[4:2] == 3'd6) begin
			return soc_bus_pkg::RESP_SLVERR; // version is read only
		end
		return soc_bus_pkg::RESP_OKAY;
	endfunction

	task automatic reload_cfg_defaults();
		cfg_board_ip  = DEF_BOARD_IP;
		cfg_host_ip   = DEF_HOST_IP;
		cfg_board_mac = DEF_BOARD_MAC;
		cfg_host_mac  = DEF_HOST_MAC;
	endtask

	task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int idx;
		idx = int'((addr >> 2) % 32'(RAM_WORDS));
		if (ram_hit(addr)) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) ram_model[idx][8*b +: 8] = data[8*b +: 8];
			end
		end else if (led_hit(addr)) begin
			page_model[addr[4:2]] = data[7:0];
		end else if (cfg_hit(addr)) begin
			case (addr[4:2])
				3'd0:    cfg_board_ip = data;
				3'd1:    cfg_host_ip = data;
				3'd2:    cfg_board_mac[47:32] = data[15:0];
				3'd3:    cfg_board_mac[31:0] = data;
				3'd4:    cfg_host_mac[47:32] = data[15:0];
				3'd5:    cfg_host_mac[31:0] = data;
				3'd7:    reload_cfg_defaults();
				default: ;
			endcase
		end
	endtask

	// one transfer; stall is how many cycles the response waits on rsp_ready
	task automatic drive_transfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb, input int stall);
		int          waited;
		logic [31:0] held_data;
		logic [1:0]  held_resp;
		req_valid <= 1'b1;
		req_write <= wr;
		req_addr  <= addr;
		req_wdata <= wdata;
		req_strb  <= strb;
		rsp_ready <= (stall == 0);
		waited = 0;
		@(posedge clk);
		while (!req_ready) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("Timeout: req_ready never came for the request");
			@(posedge clk);
		end
		req_valid <= 1'b0;
		waited = 0;
		@(posedge clk);
		while (!rsp_valid) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("Timeout: rsp_valid never came after acceptance");
			@(posedge clk);
		end
		if (stall > 0) begin
			held_data = rsp_rdata;
			held_resp = rsp_resp;
			for (int k = 1; k <= stall; k++) begin
				if (k == stall) rsp_ready <= 1'b1; // transfers on the next edge
				@(posedge clk);
				check_eq(64'(rsp_valid), 64'(1'b1), "rsp_valid under back-pressure");
				check_eq(64'(rsp_rdata), 64'(held_data), "rsp_rdata under back-pressure");
				check_eq(64'(rsp_resp), 64'(held_resp), "rsp_resp under back-pressure");
				check_eq(64'(req_ready), 64'(1'b0), "req_ready under back-pressure");
			end
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		expect_t e;
		e.addr = addr;
		e.resp = expected_write_resp(addr);
		e.data = 32'h0;
		exp_q.push_back(e);
		model_write(addr, data, strb);
		drive_transfer(1'b1, addr, data, strb, 0);
	endtask

	task automatic bus_read(input logic [31:0] addr, input int stall);
		exp_q.push_back(expected_read(addr));
		drive_transfer(1'b0, addr, 32'h0, 4'h0, stall);
	endtask

	task automatic read_all_config();
		for (int i = 0; i < 8; i++) bus_read(CFG_BASE + 32'(4 * i), 0);
	endtask

	task automatic compare_config_ports();
		check_eq(64'(board_ip), 64'(cfg_board_ip), "board_ip port");
		check_eq(64'(board_mac), 64'(cfg_board_mac), "board_mac port");
	endtask

	task automatic check_leds();
		logic [7:0] exp_led8;
		exp_led8 = ~page_model[page_idx_model]; // active low
		check_eq(64'(led4), 64'({1'b0, page_idx_model}), "led4 page index");
		check_eq(64'(led8), 64'(exp_led8), "led8 page pattern");
	endtask

	task automatic press_button(input logic up, input int hold);
		if (up) btn_up <= 1'b1;
		else btn_down <= 1'b1;
		repeat (hold) @(posedge clk);
		btn_up   <= 1'b0;
		btn_down <= 1'b0;
		repeat (hold) @(posedge clk);
		if (hold >= DEBOUNCE_CYCLES) begin
			page_idx_model = up ? page_idx_model + 3'd1 : page_idx_model - 3'd1;
		end
		check_leds();
	endtask

	task automatic check_after_reset();
		int waited;
		waited = 0;
		while (arst_n !== 1'b1) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("Timeout: reset was never released");
			@(posedge clk);
		end
		@(posedge clk);
		check_eq(64'(rsp_valid), 64'(1'b0), "rsp_valid after reset");
		check_eq(64'(req_ready), 64'(1'b1), "req_ready after reset");
		check_leds();
		compare_config_ports();
		read_all_config();
	endtask

	task automatic ram_write_read();
		logic [31:0] addr;
		for (int i = 0; i < RAM_WORDS; i++) begin
			addr = 32'(4 * i);
			bus_write(addr, addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C, 4'hF);
		end
		for (int n = 0; n < RAM_WRITES; n++) begin
			if (n % 4 == 3) begin
				// same word seen through a higher alias
				addr = (addr_list[n-1] + 32'(RAM_WORDS * 4) * ($urandom % 8 + 1)) & 32'h0FFF_FFFC;
			end else begin
				addr = $urandom & 32'h0FFF_FFFC;
			end
			addr_list[n] = addr;
			bus_write(addr, $urandom, 4'($urandom));
		end
		for (int n = 0; n < RAM_WRITES; n++) bus_read(addr_list[n], 0);
	endtask

	task automatic unmapped_access();
		bus_write(32'h5000_0000, 32'hDEAD_BEEF, 4'hF);
		bus_write(32'h9000_0000, 32'h1234_5678, 4'hF);
		bus_write(32'h1000_0000, 32'hA5A5_A5A5, 4'hF); // just past the ram window
		bus_read(32'h5000_0000, 0);
		bus_read(32'h9000_0000, 0);
		bus_read(32'hFFFF_FFFC, 0);
		bus_read(32'h0000_0000, 0);
		for (int n = 0; n < 4; n++) bus_read(addr_list[n], 0);
	endtask

	task automatic config_registers();
		bus_write(CFG_BASE + 32'h00, $urandom, 4'($urandom));
		compare_config_ports();
		bus_write(CFG_BASE + 32'h08, $urandom, 4'hF);
		bus_write(CFG_BASE + 32'h0C, $urandom, 4'hF);
		compare_config_ports();
		bus_write(CFG_BASE + 32'h04, $urandom, 4'hF);
		bus_write(CFG_BASE + 32'h10, $urandom, 4'hF);
		bus_write(CFG_BASE + 32'h14, $urandom, 4'hF);
		read_all_config();
		bus_write(CFG_BASE + 32'h18, $urandom, 4'hF);
		bus_read(CFG_BASE + 32'h18, 0);
		bus_write(CFG_BASE + 32'h1C, $urandom, 4'hF);
		read_all_config();
		check_eq(64'(board_ip), 64'(DEF_BOARD_IP), "board_ip after restore");
		check_eq(64'(board_mac), 64'(DEF_BOARD_MAC), "board_mac after restore");
	endtask

	task automatic led_pages();
		for (int p = 0; p < 8; p++) bus_write(LED_BASE + 32'(4 * p), $urandom, 4'hF);
		for (int p = 0; p < 8; p++) bus_read(LED_BASE + 32'(4 * p), 0);
		check_leds();
		for (int n = 0; n < 10; n++) press_button(1'b1, DEBOUNCE_CYCLES + 3);
		for (int n = 0; n < 3; n++) press_button(1'b0, DEBOUNCE_CYCLES + 3); // 2 -> 7
		check_eq(64'(led4), 64'(4'd7), "led4 after down wrap");
		press_button(1'b1, DEBOUNCE_CYCLES - 1);
		press_button(1'b0, DEBOUNCE_CYCLES - 1);
	endtask

	task automatic read_with_backpressure();
		logic [31:0] addr;
		for (int n = 0; n < 24; n++) begin
			case (n % 3)
				0:       addr = addr_list[int'($urandom % RAM_WRITES)];
				1:       addr = LED_BASE + 32'(4 * ($urandom % 8));
				default: addr = CFG_BASE + 32'(4 * ($urandom % 8));
			endcase
			bus_read(addr, int'($urandom % 11));
		end
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		req_valid <= 1'b0;
		req_write <= 1'b0;
		req_addr  <= 32'h0;
		req_wdata <= 32'h0;
		req_strb  <= 4'h0;
		rsp_ready <= 1'b1;
		btn_up    <= 1'b0;
		btn_down  <= 1'b0;
		for (int i = 0; i < RAM_WORDS; i++) ram_model[i] = 32'h0;
		for (int p = 0; p < 8; p++) page_model[p] = 8'h0;
		page_idx_model = 3'd0;
		reload_cfg_defaults();

		check_after_reset();
		ram_write_read();
		unmapped_access();
		config_registers();
		led_pages();
		read_with_backpressure();

		@(posedge clk);
		if (exp_q.size() != 0) begin
			abort_run("Expected responses are still missing at the end of the run");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	// compares every response that transfers against the queued expectation
	always @(posedge clk) begin : compare_responses
		expect_t e;
		if (rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				abort_run("A response arrived with no request outstanding");
			end else begin
				e = exp_q.pop_front();
				check_eq(64'(rsp_resp), 64'(e.resp), $sformatf("resp for 0x%08h", e.addr));
				check_eq(64'(rsp_rdata), 64'(e.data), $sformatf("rdata for 0x%08h", e.addr));
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1; // released on a rising edge
	end

endmodule

`default_nettype wire

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
	parameter int                             RAM_WORDS       = 256,
	parameter int                             DEBOUNCE_CYCLES = 4,
	parameter logic [soc_bus_pkg::IP_W-1:0]   DEF_BOARD_IP    = {8'd169, 8'd254, 8'd109, 8'd5},
	parameter logic [soc_bus_pkg::IP_W-1:0]   DEF_HOST_IP     = {8'd169, 8'd254, 8'd109, 8'd183},
	parameter logic [soc_bus_pkg::MAC_W-1:0]  DEF_BOARD_MAC   = 48'h12_34_56_78_9A_BC,
	parameter logic [soc_bus_pkg::MAC_W-1:0]  DEF_HOST_MAC    = 48'h84_47_09_4C_47_7C,
	parameter logic [soc_bus_pkg::DATA_W-1:0] FPGA_VERSION    = 32'h0001_0000
) (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            req_valid,
	input  wire                            req_write,
	input  wire [soc_bus_pkg::ADDR_W-1:0]  req_addr,
	input  wire [soc_bus_pkg::DATA_W-1:0]  req_wdata,
	input  wire [soc_bus_pkg::STRB_W-1:0]  req_strb,
	input  wire                            rsp_ready,
	input  wire                            btn_up,
	input  wire                            btn_down,
	output logic                           req_ready,
	output logic                           rsp_valid,
	output logic [soc_bus_pkg::DATA_W-1:0] rsp_rdata,
	output logic [1:0]                     rsp_resp,
	output logic [7:0]                     led8,
	output logic [3:0]                     led4,
	output logic [soc_bus_pkg::IP_W-1:0]   board_ip,
	output logic [soc_bus_pkg::MAC_W-1:0]  board_mac
);

	soc_bus_if slv_bus [soc_bus_pkg::NUM_SLAVES] ();

	bus_addr_decoder u_decoder (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_strb  (req_strb),
		.rsp_ready (rsp_ready),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_resp  (rsp_resp),
		.slv       (slv_bus)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (slv_bus[soc_bus_pkg::SLV_RAM])
	);

	led_page_view #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_led (
		.clk      (clk),
		.arst_n   (arst_n),
		.btn_up   (btn_up),
		.btn_down (btn_down),
		.bus      (slv_bus[soc_bus_pkg::SLV_LED]),
		.led8     (led8),
		.led4     (led4)
	);

	// host side addresses would feed the ethernet master, absent here
	net_config_regs #(
		.DEF_BOARD_IP  (DEF_BOARD_IP),
		.DEF_HOST_IP   (DEF_HOST_IP),
		.DEF_BOARD_MAC (DEF_BOARD_MAC),
		.DEF_HOST_MAC  (DEF_HOST_MAC),
		.FPGA_VERSION  (FPGA_VERSION)
	) u_cfg (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus       (slv_bus[soc_bus_pkg::SLV_CFG]),
		.board_ip  (board_ip),
		.host_ip   (),
		.board_mac (board_mac),
		.host_mac  ()
	);

endmodule

`default_nettype wire

// ==== logic/led_page_view.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_page_view #(
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        btn_up,
	input  wire        btn_down,
	soc_bus_if.slave   bus,
	output logic [7:0] led8,
	output logic [3:0] led4
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0]       btn_raw;   // bit 0 up, bit 1 down
	logic [1:0]       btn_state;
	logic [CNT_W-1:0] btn_cnt [2];
	logic [1:0]       btn_flip;
	logic [1:0]       press;

	logic [7:0]                     pages [soc_bus_pkg::LED_PAGES];
	logic [soc_bus_pkg::PAGE_W-1:0] page_idx;
	logic [soc_bus_pkg::PAGE_W-1:0] bus_page;
	logic [soc_bus_pkg::DATA_W-1:0] page_word;
	logic                           accept;

	assign btn_raw = {btn_down, btn_up};

	always_comb begin
		for (int b = 0; b < 2; b++) begin
			btn_flip[b] = (btn_raw[b] != btn_state[b]) &&
				(btn_cnt[b] == CNT_W'(DEBOUNCE_CYCLES - 1));
			press[b] = btn_flip[b] && btn_raw[b]; // debounced rising edge
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			btn_state <= '0;
			for (int b = 0; b < 2; b++) begin
				btn_cnt[b] <= '0;
			end
		end else begin
			for (int b = 0; b < 2; b++) begin
				if (btn_flip[b]) begin
					btn_state[b] <= btn_raw[b];
					btn_cnt[b]   <= '0;
				end else if (btn_raw[b] != btn_state[b]) begin
					btn_cnt[b] <= btn_cnt[b] + 1'b1;
				end else begin
					btn_cnt[b] <= '0; // bounce, start over
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			page_idx <= '0;
		end else begin
			case (press)
				2'b01:   page_idx <= page_idx + 1'b1; // wraps mod 8
				2'b10:   page_idx <= page_idx - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led8 <= '1;
			led4 <= '0;
		end else begin
			led8 <= ~pages[page_idx]; // active low
			led4 <= 4'(page_idx);
		end
	end

	assign bus_page      = bus.req_addr[soc_bus_pkg::PAGE_W+1:2];
	assign page_word     = {{(soc_bus_pkg::DATA_W - 8){1'b0}}, pages[bus_page]};
	assign bus.req_ready = !bus.rsp_valid;
	assign accept        = bus.req_valid && bus.req_ready;
	assign bus.rsp_resp  = soc_bus_pkg::RESP_OKAY;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int p = 0; p < soc_bus_pkg::LED_PAGES; p++) begin
				pages[p] <= '0;
			end
		end else if (accept && bus.req_write) begin
			pages[bus_page] <= bus.req_wdata[7:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus.rsp_valid <= 1'b0;
		end else if (accept) begin
			bus.rsp_valid <= 1'b1;
		end else if (bus.rsp_ready) begin
			bus.rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			bus.rsp_rdata <= bus.req_write ? '0 : page_word;
		end
	end

endmodule

`default_nettype wire

// ==== logic/net_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_config_regs #(
	parameter logic [soc_bus_pkg::IP_W-1:0]   DEF_BOARD_IP  = {8'd169, 8'd254, 8'd109, 8'd5},
	parameter logic [soc_bus_pkg::IP_W-1:0]   DEF_HOST_IP   = {8'd169, 8'd254, 8'd109, 8'd183},
	parameter logic [soc_bus_pkg::MAC_W-1:0]  DEF_BOARD_MAC = 48'h12_34_56_78_9A_BC,
	parameter logic [soc_bus_pkg::MAC_W-1:0]  DEF_HOST_MAC  = 48'h84_47_09_4C_47_7C,
	parameter logic [soc_bus_pkg::DATA_W-1:0] FPGA_VERSION  = 32'h0001_0000
) (
	input  wire                           clk,
	input  wire                           arst_n,
	soc_bus_if.slave                      bus,
	output logic [soc_bus_pkg::IP_W-1:0]  board_ip,
	output logic [soc_bus_pkg::IP_W-1:0]  host_ip,
	output logic [soc_bus_pkg::MAC_W-1:0] board_mac,
	output logic [soc_bus_pkg::MAC_W-1:0] host_mac
);

	soc_bus_pkg::cfg_reg_e          reg_sel;
	logic [soc_bus_pkg::DATA_W-1:0] rd_word;
	logic                           accept;

	assign reg_sel       = soc_bus_pkg::cfg_reg_e'(bus.req_addr[4:2]);
	assign bus.req_ready = !bus.rsp_valid;
	assign accept        = bus.req_valid && bus.req_ready;

	always_comb begin
		case (reg_sel)
			soc_bus_pkg::CFG_BOARD_IP:     rd_word = board_ip;
			soc_bus_pkg::CFG_HOST_IP:      rd_word = host_ip;
			soc_bus_pkg::CFG_BOARD_MAC_HI: rd_word = {16'h0000, board_mac[47:32]};
			soc_bus_pkg::CFG_BOARD_MAC_LO: rd_word = board_mac[31:0];
			soc_bus_pkg::CFG_HOST_MAC_HI:  rd_word = {16'h0000, host_mac[47:32]};
			soc_bus_pkg::CFG_HOST_MAC_LO:  rd_word = host_mac[31:0];
			soc_bus_pkg::CFG_VERSION:      rd_word = FPGA_VERSION;
			default:                       rd_word = '0; // restore is write only
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			board_ip  <= DEF_BOARD_IP;
			host_ip   <= DEF_HOST_IP;
			board_mac <= DEF_BOARD_MAC;
			host_mac  <= DEF_HOST_MAC;
		end else if (accept && bus.req_write) begin
			case (reg_sel)
				soc_bus_pkg::CFG_BOARD_IP:     board_ip <= bus.req_wdata;
				soc_bus_pkg::CFG_HOST_IP:      host_ip <= bus.req_wdata;
				soc_bus_pkg::CFG_BOARD_MAC_HI: board_mac[47:32] <= bus.req_wdata[15:0];
				soc_bus_pkg::CFG_BOARD_MAC_LO: board_mac[31:0] <= bus.req_wdata;
				soc_bus_pkg::CFG_HOST_MAC_HI:  host_mac[47:32] <= bus.req_wdata[15:0];
				soc_bus_pkg::CFG_HOST_MAC_LO:  host_mac[31:0] <= bus.req_wdata;
				soc_bus_pkg::CFG_RESTORE: begin
					// any value reloads the defaults
					board_ip  <= DEF_BOARD_IP;
					host_ip   <= DEF_HOST_IP;
					board_mac <= DEF_BOARD_MAC;
					host_mac  <= DEF_HOST_MAC;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus.rsp_valid <= 1'b0;
		end else if (accept) begin
			bus.rsp_valid <= 1'b1;
		end else if (bus.rsp_ready) begin
			bus.rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			bus.rsp_rdata <= bus.req_write ? '0 : rd_word;
			bus.rsp_resp  <= (bus.req_write && reg_sel == soc_bus_pkg::CFG_VERSION) ?
				soc_bus_pkg::RESP_SLVERR : soc_bus_pkg::RESP_OKAY;
		end
	end

endmodule

`default_nettype wire

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input wire        clk,
	input wire        arst_n,
	soc_bus_if.slave  bus
);

	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [soc_bus_pkg::DATA_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0]               word_idx;
	logic                           accept;

	// power-of-two depth, so upper bits alias inside the window
	assign word_idx = bus.req_addr[IDX_W+1:2];

	assign bus.req_ready = !bus.rsp_valid;
	assign accept        = bus.req_valid && bus.req_ready;
	assign bus.rsp_resp  = soc_bus_pkg::RESP_OKAY;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus.rsp_valid <= 1'b0;
		end else if (accept) begin
			bus.rsp_valid <= 1'b1;
		end else if (bus.rsp_ready) begin
			bus.rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			if (bus.req_write) begin
				for (int b = 0; b < soc_bus_pkg::STRB_W; b++) begin
					if (bus.req_strb[b]) begin
						mem[word_idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
					end
				end
				bus.rsp_rdata <= '0;
			end else begin
				bus.rsp_rdata <= mem[word_idx];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_addr_decoder (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            req_valid,
	input  wire                            req_write,
	input  wire [soc_bus_pkg::ADDR_W-1:0]  req_addr,
	input  wire [soc_bus_pkg::DATA_W-1:0]  req_wdata,
	input  wire [soc_bus_pkg::STRB_W-1:0]  req_strb,
	input  wire                            rsp_ready,
	output logic                           req_ready,
	output logic                           rsp_valid,
	output logic [soc_bus_pkg::DATA_W-1:0] rsp_rdata,
	output soc_bus_pkg::resp_e             rsp_resp,
	soc_bus_if.master                      slv [soc_bus_pkg::NUM_SLAVES]
);

	logic [soc_bus_pkg::NUM_SLAVES-1:0] hit;
	logic                               hit_any;
	soc_bus_pkg::slave_e                hit_idx;

	logic [soc_bus_pkg::NUM_SLAVES-1:0] s_req_ready;
	logic [soc_bus_pkg::NUM_SLAVES-1:0] s_rsp_valid;
	logic [soc_bus_pkg::DATA_W-1:0]     s_rsp_rdata [soc_bus_pkg::NUM_SLAVES];
	soc_bus_pkg::resp_e                 s_rsp_resp [soc_bus_pkg::NUM_SLAVES];

	soc_bus_pkg::dec_state_e state;
	soc_bus_pkg::slave_e     sel;     // target of the transfer in flight
	logic                    dec_err; // nobody owns the address

	genvar i;
	generate
		for (i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin : g_slv
			assign hit[i] = (req_addr >= soc_bus_pkg::SLAVE_BASE[i]) &&
				(req_addr <= soc_bus_pkg::SLAVE_LAST[i]);

			assign slv[i].req_valid = req_valid && hit[i] && (state == soc_bus_pkg::DEC_IDLE);
			assign slv[i].req_write = req_write;
			assign slv[i].req_addr  = req_addr;
			assign slv[i].req_wdata = req_wdata;
			assign slv[i].req_strb  = req_strb;
			assign slv[i].rsp_ready = rsp_ready && (state == soc_bus_pkg::DEC_WAIT) &&
				!dec_err && (sel == soc_bus_pkg::slave_e'(i));

			assign s_req_ready[i] = slv[i].req_ready;
			assign s_rsp_valid[i] = slv[i].rsp_valid;
			assign s_rsp_rdata[i] = slv[i].rsp_rdata;
			assign s_rsp_resp[i]  = slv[i].rsp_resp;
		end
	endgenerate

	assign hit_any = |hit;

	always_comb begin
		hit_idx = soc_bus_pkg::SLV_RAM;
		for (int k = 0; k < soc_bus_pkg::NUM_SLAVES; k++) begin
			if (hit[k]) begin
				hit_idx = soc_bus_pkg::slave_e'(k);
			end
		end
	end

	always_comb begin
		if (state != soc_bus_pkg::DEC_IDLE) begin
			req_ready = 1'b0;
		end else if (hit_any) begin
			req_ready = s_req_ready[hit_idx];
		end else begin
			req_ready = 1'b1; // decode errors are taken here
		end
	end

	always_comb begin
		rsp_valid = 1'b0;
		rsp_rdata = '0;
		rsp_resp  = soc_bus_pkg::RESP_OKAY;
		if (state == soc_bus_pkg::DEC_WAIT) begin
			if (dec_err) begin
				rsp_valid = 1'b1;
				rsp_resp  = soc_bus_pkg::RESP_DECERR;
			end else begin
				rsp_valid = s_rsp_valid[sel];
				rsp_rdata = s_rsp_rdata[sel];
				rsp_resp  = s_rsp_resp[sel];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= soc_bus_pkg::DEC_IDLE;
			sel     <= soc_bus_pkg::SLV_RAM;
			dec_err <= 1'b0;
		end else begin
			case (state)
				soc_bus_pkg::DEC_IDLE: begin
					if (req_valid && req_ready) begin
						state   <= soc_bus_pkg::DEC_WAIT;
						sel     <= hit_idx;
						dec_err <= !hit_any;
					end
				end
				soc_bus_pkg::DEC_WAIT: begin
					if (rsp_valid && rsp_ready) begin
						state <= soc_bus_pkg::DEC_IDLE;
					end
				end
				default: state <= soc_bus_pkg::DEC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/soc_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface soc_bus_if;

	logic                           req_valid;
	logic                           req_ready;
	logic                           req_write;
	logic [soc_bus_pkg::ADDR_W-1:0] req_addr;
	logic [soc_bus_pkg::DATA_W-1:0] req_wdata;
	logic [soc_bus_pkg::STRB_W-1:0] req_strb;

	logic                           rsp_valid;
	logic                           rsp_ready;
	logic [soc_bus_pkg::DATA_W-1:0] rsp_rdata;
	soc_bus_pkg::resp_e             rsp_resp;

	modport master (
		output req_valid, req_write, req_addr, req_wdata, req_strb, rsp_ready,
		input  req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

	modport slave (
		input  req_valid, req_write, req_addr, req_wdata, req_strb, rsp_ready,
		output req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

endinterface

`default_nettype wire

// ==== logic/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	localparam int IP_W  = 32;
	localparam int MAC_W = 48;

	localparam int LED_PAGES = 8;
	localparam int PAGE_W    = 3;

	typedef enum logic [1:0] {
		SLV_RAM = 2'd0, // stands in for the ddr3 slave
		SLV_LED = 2'd1,
		SLV_CFG = 2'd2
	} slave_e;

	localparam int NUM_SLAVES = 3;

	// inclusive windows, indexed by slave_e
	localparam logic [0:NUM_SLAVES-1][ADDR_W-1:0] SLAVE_BASE =
		{32'h0000_0000, 32'h3000_0000, 32'h7000_0000};
	localparam logic [0:NUM_SLAVES-1][ADDR_W-1:0] SLAVE_LAST =
		{32'h0FFF_FFFF, 32'h3FFF_FFFF, 32'h7FFF_FFFF};

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// word offsets, address bits 4:2
	typedef enum logic [2:0] {
		CFG_BOARD_IP     = 3'd0,
		CFG_HOST_IP      = 3'd1,
		CFG_BOARD_MAC_HI = 3'd2, // mac[47:32] in bits 15:0
		CFG_BOARD_MAC_LO = 3'd3,
		CFG_HOST_MAC_HI  = 3'd4,
		CFG_HOST_MAC_LO  = 3'd5,
		CFG_VERSION      = 3'd6,
		CFG_RESTORE      = 3'd7
	} cfg_reg_e;

	typedef enum logic {
		DEC_IDLE = 1'b0,
		DEC_WAIT = 1'b1
	} dec_state_e;

endpackage

`default_nettype wire
